// File: Makefile
VERILATOR ?= verilator
TOP       ?= playfield_tb
FILELIST  ?= playfield.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) $(VFLAGS)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/playfield_tb.sv
`default_nettype none

module playfield_tb;

localparam int NROWS       = 8;
localparam int LINE_CYCLES = 128;                       // h_count 0..127
localparam int H0          = playfield_pkg::OFFSCREEN_WIDTH;   // h_count of column 0

typedef struct packed {
    playfield_pkg::bpp_t      bpp;
    playfield_pkg::addr_t     start;
    playfield_pkg::word_t     len;
    playfield_pkg::color_t    cb;
    playfield_pkg::color_t    border;
    playfield_pkg::repeat_t   hrep;
    playfield_pkg::repeat_t   vrep;
    playfield_pkg::hres_vis_t left;
    playfield_pkg::hres_vis_t right;
    logic [7:0]               lines;                    // checked lines after warm-up
    logic                     blank;
} test_row_t;

test_row_t rows [NROWS];

logic                      clk;
logic                      reset_i;
playfield_pkg::hres_t      h_count;
logic                      mem_fetch, mem_fetch_start, end_of_line, end_of_frame;
playfield_pkg::color_t     border_color, pf_colorbase;
playfield_pkg::hres_vis_t  vid_left, vid_right;
logic                      pf_blank;
playfield_pkg::addr_t      pf_start_addr;
playfield_pkg::word_t      pf_line_len;
playfield_pkg::bpp_t       pf_bpp;
playfield_pkg::repeat_t    pf_h_repeat, pf_v_repeat;
playfield_pkg::word_t      vram_data;
logic                      vram_sel;
playfield_pkg::addr_t      vram_addr;
playfield_pkg::color_t     pf_color_index;
int                        checks, errors, test_checks, test_errors;
logic                      table_ready;
logic [31:0]               rng;

video_playfield dut_i (
    .clk(clk), .reset_i(reset_i), .h_count_i(h_count),
    .mem_fetch_i(mem_fetch), .mem_fetch_start_i(mem_fetch_start),
    .end_of_line_i(end_of_line), .end_of_frame_i(end_of_frame),
    .border_color_i(border_color), .vid_left_i(vid_left), .vid_right_i(vid_right),
    .pf_blank_i(pf_blank), .pf_start_addr_i(pf_start_addr), .pf_line_len_i(pf_line_len),
    .pf_colorbase_i(pf_colorbase), .pf_bpp_i(pf_bpp), .pf_h_repeat_i(pf_h_repeat),
    .pf_v_repeat_i(pf_v_repeat), .vram_data_i(vram_data), .vram_sel_o(vram_sel),
    .vram_addr_o(vram_addr), .pf_color_index_o(pf_color_index)
);

vram_model vram_i (
    .clk(clk), .reset_i(reset_i), .sel_i(vram_sel), .addr_i(vram_addr), .data_o(vram_data)
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                             // period 20
end

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// vram holds address ^ 5a3c rotated left by address[2:0]
function automatic playfield_pkg::word_t vram_word(input playfield_pkg::addr_t a);
    playfield_pkg::word_t v;
    int                   k;
    v = a ^ 16'h5a3c;
    for (k = 0; k < int'(a[2:0]); k++) begin
        v = {v[14:0], v[15]};
    end
    return v;
endfunction

// word address where frame line `line` begins
function automatic playfield_pkg::addr_t line_start_addr(input int r, input int line);
    if (rows[r].blank) begin
        return rows[r].start;                           // blank pins the start
    end
    return rows[r].start +
           playfield_pkg::addr_t'(int'(rows[r].len) * (line / (int'(rows[r].vrep) + 1)));
endfunction

// color seen at h_count h of frame line `line`
function automatic playfield_pkg::color_t expected_color(input int r, input int line,
                                                         input int h);
    int                    p, g, i, wpg, k;
    playfield_pkg::addr_t  base;
    playfield_pkg::word_t  w [4];
    playfield_pkg::color_t pix;
    if (h < H0 + int'(rows[r].left) || h >= H0 + int'(rows[r].right)) begin
        return rows[r].border ^ rows[r].cb;             // outside the window
    end
    p   = (h - H0 - int'(rows[r].left)) / (int'(rows[r].hrep) + 1);   // source pixel
    g   = p / 8;                                        // word group
    i   = p % 8;                                        // pixel in group
    wpg = (rows[r].bpp == playfield_pkg::BPP_1_ATTR) ? 1 :
          (rows[r].bpp == playfield_pkg::BPP_4) ? 2 : 4;
    base = line_start_addr(r, line);
    for (k = 0; k < 4; k++) begin
        w[k] = vram_word(rows[r].blank ? rows[r].start :
                         base + playfield_pkg::addr_t'(g * wpg + k));   // blank pins reads
    end
    case (rows[r].bpp)
        playfield_pkg::BPP_1_ATTR: begin
            pix = {4'h0, w[0][7 - i] ? w[0][playfield_pkg::ATTR_FORE_LSB +: 4] :
                                       w[0][playfield_pkg::ATTR_BACK_LSB +: 4]};
        end
        playfield_pkg::BPP_4: pix = {4'h0, w[i / 4][4 * (3 - i % 4) +: 4]};   // msb nibble first
        default:              pix = (i % 2 == 0) ? w[i / 2][15:8] : w[i / 2][7:0];
    endcase
    return pix ^ rows[r].cb;
endfunction

task automatic set_row(input int idx, input playfield_pkg::bpp_t bpp,
                       input playfield_pkg::addr_t start, input playfield_pkg::word_t len,
                       input playfield_pkg::color_t cb, input playfield_pkg::color_t border,
                       input playfield_pkg::repeat_t hrep, input playfield_pkg::repeat_t vrep,
                       input playfield_pkg::hres_vis_t left,
                       input playfield_pkg::hres_vis_t right,
                       input logic [7:0] lines, input logic blank);
    rows[idx] = '{bpp, start, len, cb, border, hrep, vrep, left, right, lines, blank};
endtask

task automatic load_params(input int r);
    pf_bpp        <= rows[r].bpp;
    pf_start_addr <= rows[r].start;
    pf_line_len   <= rows[r].len;
    pf_colorbase  <= rows[r].cb;
    border_color  <= rows[r].border;
    pf_h_repeat   <= rows[r].hrep;
    pf_v_repeat   <= rows[r].vrep;
    vid_left      <= rows[r].left;
    vid_right     <= rows[r].right;
    pf_blank      <= rows[r].blank;
endtask

// one scanline; line 0 of a row is warm-up and ends the frame
task automatic run_line(input int r, input int t);
    int                    h, frame_line;
    logic                  eof;
    logic                  read_seen;                   // first vram read of the line
    playfield_pkg::color_t exp_c;
    playfield_pkg::addr_t  exp_a;
    frame_line = (t == 0) ? 0 : (t - 1) % 4;
    eof        = (t == 0) || (frame_line == 3);         // 4 lines per frame
    read_seen  = 1'b0;
    exp_a      = line_start_addr(r, frame_line);
    for (h = 0; h < LINE_CYCLES; h++) begin
        @(posedge clk);
        if (t == 0 && h == 0) begin
            load_params(r);
        end
        h_count         <= playfield_pkg::hres_t'(h);
        mem_fetch       <= (h >= 4) && (h < H0 + int'(rows[r].right));
        mem_fetch_start <= (h == 2);
        end_of_line     <= (h == LINE_CYCLES - 1);
        end_of_frame    <= eof && (h == LINE_CYCLES - 1);
        @(negedge clk);                                 // outputs settled
        if (t > 0) begin
            exp_c = expected_color(r, frame_line, h);
            checks++;
            test_checks++;
            if (pf_color_index !== exp_c) begin
                errors++;
                test_errors++;
                $display("Mismatch pf_color_index_o: test %0d line %0d h %0d got %h expected %h",
                         r, t, h, pf_color_index, exp_c);
            end
        end
        if (t > 0 && !read_seen && vram_sel === 1'b1) begin
            read_seen = 1'b1;
            checks++;
            test_checks++;
            if (vram_addr !== exp_a) begin
                errors++;
                test_errors++;
                $display("Mismatch vram_addr_o: test %0d line %0d got %h expected %h",
                         r, t, vram_addr, exp_a);
            end
        end
    end
    if (t > 0 && !read_seen) begin
        errors++;
        test_errors++;
        $display("Test %0d line %0d issued no VRAM read", r, t);
    end
endtask

initial begin
    longint limit;
    int     total, r;
    total = 0;
    wait (table_ready === 1'b1);
    for (r = 0; r < NROWS; r++) begin
        total += int'(rows[r].lines) + 1;
    end
    limit = longint'(total * LINE_CYCLES + 200) * 64'd20;
    #(limit);
    $display("Timeout: the tests did not finish within %0d time units", limit);
    $display("Something failed");
    $finish;
end

initial begin
    int r, t, c;
    reset_i = 1'b1;
    h_count = '0;
    mem_fetch = 1'b0;
    mem_fetch_start = 1'b0;
    end_of_line = 1'b0;
    end_of_frame = 1'b0;
    checks = 0;
    errors = 0;
    table_ready = 1'b0;
    rng = 32'hf61b_e433;
    //      bpp    start     len     cb     border hrep  vrep  left    right    lines blank
    set_row(0, 2'd2, 16'h0000, 16'd40, 8'h00, 8'h11, 2'd0, 2'd0, 11'd0,  11'd64,  8'd6, 1'b0);
    set_row(1, 2'd1, 16'h1000, 16'd24, 8'h30, 8'h05, 2'd0, 2'd1, 11'd8,  11'd72,  8'd6, 1'b0);
    set_row(2, 2'd0, 16'h2000, 16'd10, 8'h00, 8'h0f, 2'd1, 2'd0, 11'd4,  11'd84,  8'd5, 1'b0);
    set_row(3, 2'd2, 16'h3000, 16'd64, 8'h80, 8'h22, 2'd2, 2'd2, 11'd3,  11'd90,  8'd7, 1'b0);
    set_row(4, 2'd1, 16'h4000, 16'd48, 8'h00, 8'h3c, 2'd3, 2'd3, 11'd0,  11'd96,  8'd9, 1'b0);
    set_row(5, 2'd0, 16'h5000, 16'd16, 8'h40, 8'h07, 2'd3, 2'd1, 11'd20, 11'd100, 8'd5, 1'b0);
    set_row(6, 2'd3, 16'h6000, 16'd32, 8'h00, 8'h99, 2'd1, 2'd0, 11'd5,  11'd60,  8'd4, 1'b0);
    set_row(7, 2'd2, 16'h7000, 16'd40, 8'h00, 8'h44, 2'd0, 2'd1, 11'd2,  11'd70,  8'd4, 1'b1);
    for (r = 0; r < NROWS; r++) begin
        rng = lcg_next(rng);
        rows[r].start = rows[r].start ^ rng[31:16];     // scatter start address
        rng = lcg_next(rng);
        rows[r].cb = rows[r].cb ^ rng[23:16];
    end
    load_params(0);                                     // nba at time 0 before any edge
    table_ready = 1'b1;

    repeat (3) @(posedge clk);
    reset_i <= 1'b0;
    for (c = 0; c < 4; c++) begin                       // idle outputs before first fetch
        @(negedge clk);
        checks += 2;
        if (pf_color_index !== 8'h00) begin
            errors++;
            $display("Mismatch pf_color_index_o after reset: got %h expected %h",
                     pf_color_index, 8'h00);
        end
        if (vram_sel !== 1'b0) begin
            errors++;
            $display("Mismatch vram_sel_o after reset: got %h expected %h", vram_sel, 1'b0);
        end
    end
    $display("reset: idle outputs checked, %0d errors", errors);

    for (r = 0; r < NROWS; r++) begin
        test_checks = 0;
        test_errors = 0;
        for (t = 0; t <= int'(rows[r].lines); t++) begin
            run_line(r, t);
        end
        $display("test %0d bpp %0d h_repeat %0d v_repeat %0d blank %0d: %0d checks, %0d mismatches",
                 r, rows[r].bpp, rows[r].hrep, rows[r].vrep, rows[r].blank,
                 test_checks, test_errors);
    end

    $display("%0d tests, %0d checks, %0d errors", NROWS, checks, errors);
    if (errors == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: bench/vram_model.sv
`default_nettype none

module vram_model (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  sel_i,
    input  wire playfield_pkg::addr_t  addr_i,
    output      playfield_pkg::word_t  data_o      // one cycle after sel, two after issue
);

playfield_pkg::word_t scrambled;
logic [31:0]          twice;                        // word repeated for the rotate
logic [31:0]          rotated;

assign scrambled = addr_i ^ 16'h5a3c;
assign twice     = {scrambled, scrambled};
assign rotated   = twice >> (5'd16 - {2'b00, addr_i[2:0]});   // rotl by low 3 bits

always_ff @(posedge clk) begin
    if (reset_i) begin
        data_o <= '0;
    end else if (sel_i) begin
        data_o <= rotated[15:0];
    end
end

endmodule

`default_nettype wire

// File: playfield.f
rtl/playfield_pkg.sv
rtl/playfield_line_addr.sv
rtl/playfield_fetch.sv
rtl/playfield_expand.sv
rtl/playfield_scanout.sv
rtl/video_playfield.sv
bench/vram_model.sv
bench/playfield_tb.sv

// File: rtl/playfield_expand.sv
`default_nettype none

module playfield_expand (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   mem_fetch_start_i,
    input  wire logic                   words_ready_i,
    input  wire logic                   buf_take_i,
    input  wire playfield_pkg::bpp_t    pf_bpp_i,
    input  wire playfield_pkg::word_t   attr_word_i,
    input  wire playfield_pkg::word_t   data_word0_i,
    input  wire playfield_pkg::word_t   data_word1_i,
    input  wire playfield_pkg::word_t   data_word2_i,
    input  wire playfield_pkg::word_t   data_word3_i,
    output      playfield_pkg::pixels_t pixels_buf_o,     // next 8 pixels, leftmost on top
    output      logic                   buf_full_o
);

playfield_pkg::pixels_t expanded;
playfield_pkg::pixels_t wide;                           // 8 bpp words as-is
logic [31:0]            nibbles;                        // 4 bpp words

always_comb begin
    wide    = {data_word0_i, data_word1_i, data_word2_i, data_word3_i};
    nibbles = {data_word0_i, data_word1_i};
    for (int i = 0; i < 8; i++) begin
        case (pf_bpp_i)
            playfield_pkg::BPP_1_ATTR: begin
                expanded[63-8*i -: 8] = {4'h0, data_word0_i[7-i] ?
                                         attr_word_i[playfield_pkg::ATTR_FORE_LSB +: 4] :
                                         attr_word_i[playfield_pkg::ATTR_BACK_LSB +: 4]};
            end
            playfield_pkg::BPP_4: begin
                expanded[63-8*i -: 8] = {4'h0, nibbles[31-4*i -: 4]};
            end
            default: begin
                expanded[63-8*i -: 8] = wide[63-8*i -: 8];    // 8 bpp and code 3
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        buf_full_o <= 1'b0;
    end else begin
        if (buf_take_i) begin
            buf_full_o <= 1'b0;
        end
        if (words_ready_i) begin
            buf_full_o <= 1'b1;                         // new group wins
        end
        if (mem_fetch_start_i) begin
            buf_full_o <= 1'b0;                         // fresh line
        end
    end
end

always_ff @(posedge clk) begin
    if (words_ready_i) begin
        pixels_buf_o <= expanded;
    end
end

endmodule

`default_nettype wire

// File: rtl/playfield_fetch.sv
`default_nettype none

module playfield_fetch (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   mem_fetch_i,
    input  wire logic                   mem_fetch_start_i,
    input  wire logic                   end_of_line_i,
    input  wire logic                   frame_restart_i,
    input  wire playfield_pkg::addr_t   line_start_i,
    input  wire playfield_pkg::addr_t   pf_start_addr_i,
    input  wire playfield_pkg::bpp_t    pf_bpp_i,
    input  wire logic                   buf_full_i,         // no new group while set
    input  wire playfield_pkg::word_t   vram_data_i,
    output      logic                   vram_sel_o,
    output      playfield_pkg::addr_t   vram_addr_o,
    output      logic                   words_ready_o,      // previous group complete
    output      playfield_pkg::word_t   attr_word_o,
    output      playfield_pkg::word_t   data_word0_o,
    output      playfield_pkg::word_t   data_word1_o,
    output      playfield_pkg::word_t   data_word2_o,
    output      playfield_pkg::word_t   data_word3_o
);

playfield_pkg::fetch_st_t state, state_next;
playfield_pkg::addr_t     pf_addr, pf_addr_next;        // running display address
playfield_pkg::addr_t     addr_next;
logic                     issue;                        // put pf_addr on vram bus
logic                     initial_buf, initial_buf_next; // first group of line
logic                     ready_next;

always_comb begin
    state_next       = state;
    initial_buf_next = initial_buf;
    ready_next       = 1'b0;
    issue            = 1'b0;

    case (state)
        playfield_pkg::IDLE: begin
            if (mem_fetch_i) begin
                state_next = playfield_pkg::ADDR;
            end
        end
        playfield_pkg::ADDR: begin
            if (!mem_fetch_i) begin
                state_next = playfield_pkg::IDLE;           // fetch window over
            end else if (!buf_full_i) begin
                issue      = 1'b1;                          // word0
                state_next = playfield_pkg::WAIT;
            end
        end
        playfield_pkg::WAIT: begin
            issue            = (pf_bpp_i != playfield_pkg::BPP_1_ATTR);  // word1
            ready_next       = !initial_buf;                // first group only primes
            initial_buf_next = 1'b0;
            state_next       = playfield_pkg::READ_0;
        end
        playfield_pkg::READ_0: begin
            if (pf_bpp_i == playfield_pkg::BPP_1_ATTR) begin
                state_next = playfield_pkg::ADDR;           // single word group
            end else begin
                issue      = (pf_bpp_i >= playfield_pkg::BPP_8);  // word2
                state_next = playfield_pkg::READ_1;
            end
        end
        playfield_pkg::READ_1: begin
            if (pf_bpp_i == playfield_pkg::BPP_4) begin
                state_next = playfield_pkg::ADDR;
            end else begin
                issue      = 1'b1;                          // word3
                state_next = playfield_pkg::READ_2;
            end
        end
        playfield_pkg::READ_2: state_next = playfield_pkg::READ_3;
        playfield_pkg::READ_3: state_next = playfield_pkg::ADDR;
        default:               state_next = playfield_pkg::IDLE;
    endcase

    addr_next    = issue ? pf_addr : vram_addr_o;
    pf_addr_next = issue ? pf_addr + 1'b1 : pf_addr;
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state         <= playfield_pkg::IDLE;
        pf_addr       <= '0;
        vram_sel_o    <= 1'b0;
        vram_addr_o   <= '0;
        initial_buf   <= 1'b0;
        words_ready_o <= 1'b0;
    end else begin
        state         <= state_next;
        pf_addr       <= pf_addr_next;
        vram_sel_o    <= issue;
        vram_addr_o   <= addr_next;
        initial_buf   <= initial_buf_next;
        words_ready_o <= ready_next;

        if (mem_fetch_start_i) begin
            initial_buf <= 1'b1;
            pf_addr     <= line_start_i;
        end
        if (end_of_line_i) begin
            state   <= playfield_pkg::IDLE;                 // abandon partial group
            pf_addr <= line_start_i;
        end
        if (frame_restart_i) begin
            pf_addr <= pf_start_addr_i;
        end
    end
end

// capture returned words, two cycles after the address decision
always_ff @(posedge clk) begin
    case (state)
        playfield_pkg::READ_0: begin
            data_word0_o <= vram_data_i;
            attr_word_o  <= vram_data_i;                    // 1 bpp colors share word0
        end
        playfield_pkg::READ_1: data_word1_o <= vram_data_i;
        playfield_pkg::READ_2: data_word2_o <= vram_data_i;
        playfield_pkg::READ_3: data_word3_o <= vram_data_i;
        default: ;
    endcase
end

endmodule

`default_nettype wire

// File: rtl/playfield_line_addr.sv
`default_nettype none

module playfield_line_addr (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    end_of_line_i,
    input  wire logic                    end_of_frame_i,
    input  wire logic                    pf_blank_i,
    input  wire playfield_pkg::addr_t    pf_start_addr_i,
    input  wire playfield_pkg::word_t    pf_line_len_i,
    input  wire playfield_pkg::repeat_t  pf_v_repeat_i,
    output      playfield_pkg::addr_t    line_start_o,     // address of current line
    output      logic                    frame_restart_o   // reload running fetch address
);

playfield_pkg::repeat_t v_count;                        // lines left before advancing

always_ff @(posedge clk) begin
    if (reset_i) begin
        line_start_o    <= '0;
        v_count         <= '0;
        frame_restart_o <= 1'b0;
    end else begin
        frame_restart_o <= end_of_frame_i | pf_blank_i;     // held blank keeps restarting

        if (end_of_line_i) begin
            if (v_count != '0) begin
                v_count      <= v_count - 1'b1;             // repeat same line
            end else begin
                v_count      <= pf_v_repeat_i;
                line_start_o <= line_start_o + pf_line_len_i;   // next source line
            end
        end

        // frame restart wins over line advance
        if (end_of_frame_i || pf_blank_i) begin
            line_start_o <= pf_start_addr_i;
            v_count      <= pf_v_repeat_i;
        end
    end
end

endmodule

`default_nettype wire

// File: rtl/playfield_pkg.sv
`default_nettype none

package playfield_pkg;

typedef logic [15:0] word_t;                // vram data word
typedef logic [15:0] addr_t;                // vram word address
typedef logic [7:0]  color_t;               // color index
typedef logic [10:0] hres_t;                // horizontal timing count
typedef logic [10:0] hres_vis_t;            // visible horizontal position
typedef logic [1:0]  bpp_t;                 // color depth code
typedef logic [1:0]  repeat_t;              // n gives n+1 copies
typedef logic [63:0] pixels_t;              // eight packed color indices

localparam bpp_t BPP_1_ATTR = 2'd0;         // 1 bpp, fore/back nibbles in same word
localparam bpp_t BPP_4      = 2'd1;         // 4 bpp, two words per group
localparam bpp_t BPP_8      = 2'd2;         // 8 bpp, four words (code 3 acts the same)

localparam int ATTR_FORE_LSB = 12;          // foreground nibble of 1 bpp word
localparam int ATTR_BACK_LSB = 8;           // background nibble of 1 bpp word

localparam int OFFSCREEN_WIDTH = 16;        // h_count of visible column 0
localparam int SCANOUT_LEAD    = 2;         // shift register + output register latency

typedef enum logic [2:0] {
    IDLE,                                   // waiting for mem_fetch
    ADDR,                                   // first address of a group
    WAIT,                                   // read latency, second address
    READ_0,                                 // word0 returned
    READ_1,
    READ_2,
    READ_3                                  // last 8 bpp word
} fetch_st_t;

endpackage

`default_nettype wire

// File: rtl/playfield_scanout.sv
`default_nettype none

module playfield_scanout (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire playfield_pkg::hres_t      h_count_i,
    input  wire logic                      mem_fetch_i,
    input  wire logic                      mem_fetch_start_i,
    input  wire logic                      end_of_line_i,
    input  wire playfield_pkg::hres_vis_t  vid_left_i,
    input  wire playfield_pkg::hres_vis_t  vid_right_i,
    input  wire playfield_pkg::color_t     border_color_i,
    input  wire playfield_pkg::color_t     pf_colorbase_i,
    input  wire playfield_pkg::repeat_t    pf_h_repeat_i,
    input  wire playfield_pkg::pixels_t    pixels_buf_i,
    output      logic                      buf_take_o,        // buffer copied to shifter
    output      playfield_pkg::color_t     pf_color_index_o
);

localparam playfield_pkg::hres_t H_LEAD =
    playfield_pkg::hres_t'(playfield_pkg::OFFSCREEN_WIDTH - playfield_pkg::SCANOUT_LEAD);

playfield_pkg::hres_t   start_h, end_h;                 // scanout window in h_count
logic                   scan_start, scan_end;
logic                   scanout;                        // shifter running
logic                   shown;                          // a line has begun since reset
playfield_pkg::repeat_t h_cnt;                          // copies left of current pixel
logic [2:0]             pix_idx;                        // pixel within group of 8
logic                   shift_now, reload;
playfield_pkg::pixels_t pixels;                         // shifter, top byte is output

assign start_h    = H_LEAD + vid_left_i;
assign end_h      = H_LEAD + vid_right_i;
assign scan_start = (h_count_i == start_h) && mem_fetch_i;
assign scan_end   = (h_count_i == end_h);
assign shift_now  = scanout && (h_cnt == '0);
assign reload     = shift_now && (pix_idx == 3'd7);     // eighth pixel done

always_ff @(posedge clk) begin
    if (reset_i) begin
        scanout          <= 1'b0;
        shown            <= 1'b0;
        h_cnt            <= '0;
        pix_idx          <= '0;
        buf_take_o       <= 1'b0;
        pf_color_index_o <= '0;
    end else begin
        buf_take_o <= reload | scan_start;
        if (scanout) begin
            h_cnt <= (h_cnt != '0) ? h_cnt - 1'b1 : pf_h_repeat_i;
        end
        if (shift_now) begin
            pix_idx <= pix_idx + 1'b1;                  // wraps to 0 on reload
        end
        if (mem_fetch_start_i) begin
            shown <= 1'b1;
        end
        if (scan_start) begin
            scanout <= 1'b1;
            h_cnt   <= pf_h_repeat_i;
            pix_idx <= '0;
        end
        if (scan_end || end_of_line_i) begin
            scanout <= 1'b0;
        end
        if (shown) begin
            pf_color_index_o <= pixels[63:56] ^ pf_colorbase_i;   // one cycle of latency
        end
    end
end

always_ff @(posedge clk) begin
    if (reload || scan_start) begin
        pixels <= pixels_buf_i;                         // next 8 pixels
    end else if (shift_now) begin
        pixels <= {pixels[55:0], border_color_i};       // border fills behind
    end
    if (mem_fetch_start_i || scan_end || end_of_line_i) begin
        pixels[63:56] <= border_color_i;                // border outside window
    end
end

endmodule

`default_nettype wire

// File: rtl/video_playfield.sv
`default_nettype none

module video_playfield (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire playfield_pkg::hres_t      h_count_i,          // horizontal timing count
    input  wire logic                      mem_fetch_i,        // line fetch allowed
    input  wire logic                      mem_fetch_start_i,  // pulse before fetching
    input  wire logic                      end_of_line_i,
    input  wire logic                      end_of_frame_i,
    input  wire playfield_pkg::color_t     border_color_i,
    input  wire playfield_pkg::hres_vis_t  vid_left_i,         // first visible column
    input  wire playfield_pkg::hres_vis_t  vid_right_i,        // last visible column + 1
    input  wire logic                      pf_blank_i,
    input  wire playfield_pkg::addr_t      pf_start_addr_i,
    input  wire playfield_pkg::word_t      pf_line_len_i,      // words per line
    input  wire playfield_pkg::color_t     pf_colorbase_i,
    input  wire playfield_pkg::bpp_t       pf_bpp_i,
    input  wire playfield_pkg::repeat_t    pf_h_repeat_i,
    input  wire playfield_pkg::repeat_t    pf_v_repeat_i,
    input  wire playfield_pkg::word_t      vram_data_i,
    output      logic                      vram_sel_o,
    output      playfield_pkg::addr_t      vram_addr_o,
    output      playfield_pkg::color_t     pf_color_index_o
);

playfield_pkg::addr_t   line_start;                         // start of current line
logic                   frame_restart;
logic                   words_ready;                        // fetch -> expand
playfield_pkg::word_t   attr_word;
playfield_pkg::word_t   data_word0, data_word1, data_word2, data_word3;
logic                   buf_full;                           // expand -> fetch
logic                   buf_take;                           // scanout -> expand
playfield_pkg::pixels_t pixels_buf;

playfield_line_addr line_addr_i (
    .clk(clk), .reset_i(reset_i),
    .end_of_line_i(end_of_line_i), .end_of_frame_i(end_of_frame_i),
    .pf_blank_i(pf_blank_i), .pf_start_addr_i(pf_start_addr_i),
    .pf_line_len_i(pf_line_len_i), .pf_v_repeat_i(pf_v_repeat_i),
    .line_start_o(line_start), .frame_restart_o(frame_restart)
);

playfield_fetch fetch_i (
    .clk(clk), .reset_i(reset_i),
    .mem_fetch_i(mem_fetch_i), .mem_fetch_start_i(mem_fetch_start_i),
    .end_of_line_i(end_of_line_i), .frame_restart_i(frame_restart),
    .line_start_i(line_start), .pf_start_addr_i(pf_start_addr_i),
    .pf_bpp_i(pf_bpp_i), .buf_full_i(buf_full), .vram_data_i(vram_data_i),
    .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o),
    .words_ready_o(words_ready), .attr_word_o(attr_word),
    .data_word0_o(data_word0), .data_word1_o(data_word1),
    .data_word2_o(data_word2), .data_word3_o(data_word3)
);

playfield_expand expand_i (
    .clk(clk), .reset_i(reset_i),
    .mem_fetch_start_i(mem_fetch_start_i), .words_ready_i(words_ready),
    .buf_take_i(buf_take), .pf_bpp_i(pf_bpp_i), .attr_word_i(attr_word),
    .data_word0_i(data_word0), .data_word1_i(data_word1),
    .data_word2_i(data_word2), .data_word3_i(data_word3),
    .pixels_buf_o(pixels_buf), .buf_full_o(buf_full)
);

playfield_scanout scanout_i (
    .clk(clk), .reset_i(reset_i),
    .h_count_i(h_count_i), .mem_fetch_i(mem_fetch_i),
    .mem_fetch_start_i(mem_fetch_start_i), .end_of_line_i(end_of_line_i),
    .vid_left_i(vid_left_i), .vid_right_i(vid_right_i),
    .border_color_i(border_color_i), .pf_colorbase_i(pf_colorbase_i),
    .pf_h_repeat_i(pf_h_repeat_i), .pixels_buf_i(pixels_buf),
    .buf_take_o(buf_take), .pf_color_index_o(pf_color_index_o)
);

endmodule

`default_nettype wire
